/* tb.f */
src/icache_pkg.sv
src/icache_store.sv
src/icache_refill.sv
src/fetch_seq.sv
src/icache_top.sv
tests/axi_rom_model.sv
tests/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the instruction cache testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module icache_tb \
    -f tb.f \
    --Mdir obj_dir \
    -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

/* tests/icache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    typedef struct packed {
        addr_t redirect_pc;
        int    count;                                    // strobes to collect
        int    expect_refill;                            // AR handshakes in the window
    } entry_t;

    localparam int n_entries = 10;

    logic       clk = 1'b0;
    logic       reset;
    logic       redirect;
    addr_t      redirect_pc;
    logic       fetch_valid;
    fetch_out_t fetch_out;
    axi_id_t    arid;
    addr_t      araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       arlock;
    logic [3:0] arcache;
    logic [2:0] arprot;
    logic       arvalid;
    logic       arready;
    axi_id_t    rid;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rlast;
    logic       rvalid;
    logic       rready;

    int    cycle = 0;
    int    errors = 0;
    int    passed = 0;
    int    failed = 0;
    addr_t ar_q [$];

    // a count of 0 lets the next redirect land while this refill is in flight
    entry_t stim [n_entries] = '{
        '{64'h0000_0000, 12, 1},                         // cold start after reset
        '{64'h0000_1234, 20, 3},                         // critical word first
        '{64'h0000_1234, 20, 0},                         // refetch, all hits
        '{64'h0000_0008,  8, 0},
        '{64'h0000_5210,  4, 1},                         // same index, other tag
        '{64'h0000_1210,  4, 1},                         // back to the evicted line
        '{64'h0000_2000,  0, 0},
        '{64'h0000_2400,  8, 2},                         // waits for the 0x2000 burst
        '{64'h0000_2004, 10, 0},                         // line filled under redirect
        '{64'h0000_3000, 40, 3}
    };

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    icache_top u_icache_top (.*);

    axi_rom_model u_axi_rom_model (.*);

    function automatic inst_t expected_inst(input addr_t pc);
        return pc[31:0] ^ 32'h5a5a_0000;
    endfunction

    task automatic report_mismatch(input string what, input int entry, input addr_t seen,
                                   input addr_t want);
        $display("Error at %0t ns: entry %0d %s is %h, expected %h", $time, entry, what,
                 seen, want);
        errors++;
    endtask

    // AR handshakes, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && arvalid && arready) begin
            ar_q.push_back(araddr);
            assert (arlen == 8'd7 && arsize == 3'd3 && arburst == 2'd2 && arid == '0) else begin
                $display("Error at %0t ns: AR len %0d size %0d burst %0d id %0d, expected 7 3 2 0",
                         $time, arlen, arsize, arburst, arid);
                errors++;
            end
            assert (arlock == 1'b0 && arcache == 4'd0 && arprot == 3'd6) else begin
                $display("Error at %0t ns: AR lock %0d cache %0d prot %0d, expected 0 0 6",
                         $time, arlock, arcache, arprot);
                errors++;
            end
        end
    end

    initial begin
        addr_t exp_pc;
        addr_t exp_ar;
        addr_t pend_pc;
        logic  pend;
        int    got;
        int    last_cycle;
        int    errors_before;
        string status;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        pend        = 1'b0;
        pend_pc     = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!fetch_valid && !arvalid && !rready) else begin
            $display("Error at %0t ns: reset state valid %b arvalid %b rready %b, expected 0",
                     $time, fetch_valid, arvalid, rready);
            errors++;
        end
        for (int i = 0; i < n_entries; i++) begin
            errors_before = errors;
            @(posedge clk);
            redirect    <= 1'b1;
            redirect_pc <= stim[i].redirect_pc;
            ar_q.delete();
            @(posedge clk);
            redirect <= 1'b0;
            exp_pc = stim[i].redirect_pc;
            exp_ar = (pend ? pend_pc : stim[i].redirect_pc) & ~64'h7;
            got = 0;
            last_cycle = 0;
            while (got < stim[i].count) begin
                @(negedge clk);
                if (fetch_valid) begin
                    assert (fetch_out.pc == exp_pc) else
                        report_mismatch("pc", i, fetch_out.pc, exp_pc);
                    assert (fetch_out.inst == expected_inst(exp_pc)) else
                        report_mismatch("inst", i, 64'(fetch_out.inst),
                                        64'(expected_inst(exp_pc)));
                    if (stim[i].expect_refill == 0 && got > 0) begin
                        assert (cycle == last_cycle + 1) else begin
                            $display("Error at %0t ns: entry %0d hit run has a gap of %0d cycles",
                                     $time, i, cycle - last_cycle);
                            errors++;
                        end
                    end
                    last_cycle = cycle;
                    exp_pc = exp_pc + 64'd4;
                    got++;
                end
            end
            assert (ar_q.size() == stim[i].expect_refill) else begin
                $display("Error at %0t ns: entry %0d saw %0d AR handshakes, expected %0d",
                         $time, i, ar_q.size(), stim[i].expect_refill);
                errors++;
            end
            if (stim[i].expect_refill > 0 && ar_q.size() > 0) begin
                assert (ar_q[0] == exp_ar) else
                    report_mismatch("araddr", i, ar_q[0], exp_ar);
            end
            pend = (stim[i].count == 0);
            pend_pc = stim[i].redirect_pc;
            if (errors == errors_before) begin
                passed++;
                status = "ok";
            end else begin
                failed++;
                status = "FAILED";
            end
            $display("entry %0d redirect %h: %0d instructions, %0d refills, %s", i,
                     stim[i].redirect_pc, got, ar_q.size(), status);
        end
        $display("%0d entries passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = 200;
        for (int k = 0; k < n_entries; k++) begin
            limit += stim[k].count * 40;
        end
        while (cycle < limit) @(posedge clk);
        $display("timeout after %0d cycles, the fetch stream stalled", limit);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/axi_rom_model.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_rom_model (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire icache_pkg::addr_t    araddr,
    input  wire logic                 arvalid,
    output logic                      arready,
    output icache_pkg::axi_id_t       rid,
    output icache_pkg::word_t         rdata,
    output logic [1:0]                rresp,
    output logic                      rlast,
    output logic                      rvalid,
    input  wire logic                 rready
);
    import icache_pkg::*;

    integer      seed = 32'h96da6f5e;
    logic [31:0] rnd;
    logic        busy;                                   // burst in progress
    addr_t       base;
    logic [2:0]  beat;

    assign rid   = '0;
    assign rresp = 2'b00;

    function automatic inst_t inst_at(input addr_t a);
        return a[31:0] ^ 32'h5a5a_0000;
    endfunction

    // wraps inside the 64-byte line, first beat is the requested word
    function automatic word_t beat_word(input addr_t start, input logic [2:0] n);
        addr_t      a;
        logic [2:0] slot;
        slot = start[5:3] + n;
        a = {start[63:6], slot, 3'b000};
        return {inst_at(a + 64'd4), inst_at(a)};
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            busy    <= 1'b0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy    <= 1'b1;
                base    <= araddr;
                beat    <= 3'd0;
                arready <= 1'b0;
            end else begin
                arready <= rnd[0];                       // random address wait
            end
        end else if (rvalid && rready) begin
            if (rlast) begin
                rvalid <= 1'b0;
                busy   <= 1'b0;
            end else begin
                beat   <= beat + 3'd1;
                rvalid <= (rnd[2:1] != 2'b00);           // next beat or a gap
                rdata  <= beat_word(base, beat + 3'd1);
                rlast  <= (beat == 3'd6);
            end
        end else if (!rvalid && rnd[2:1] != 2'b00) begin
            rvalid <= 1'b1;
            rdata  <= beat_word(base, beat);
            rlast  <= (beat == 3'd7);
        end
    end

endmodule

`default_nettype wire

/* src/icache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  wire logic                 clk,
    input  wire logic                 reset,

    // fetch side
    input  wire logic                 redirect,
    input  wire icache_pkg::addr_t    redirect_pc,
    output logic                      fetch_valid,
    output icache_pkg::fetch_out_t    fetch_out,

    // AXI4 read master
    output icache_pkg::axi_id_t       arid,
    output icache_pkg::addr_t         araddr,
    output logic [7:0]                arlen,
    output logic [2:0]                arsize,
    output logic [1:0]                arburst,
    output logic                      arlock,
    output logic [3:0]                arcache,
    output logic [2:0]                arprot,
    output logic                      arvalid,
    input  wire logic                 arready,
    input  wire icache_pkg::axi_id_t  rid,
    input  wire icache_pkg::word_t    rdata,
    input  wire logic [1:0]           rresp,
    input  wire logic                 rlast,
    input  wire logic                 rvalid,
    output logic                      rready
);
    import icache_pkg::*;

    addr_t   lookup_pc;
    logic    hit;
    inst_t   hit_inst;

    logic    tag_wr;
    index_t  tag_wr_index;
    tag_t    tag_wr_tag;
    logic    data_wr;
    index_t  data_wr_index;
    offset_t data_wr_offset;
    word_t   data_wr_word;
    logic    line_done;
    index_t  line_done_index;

    fetch_seq u_fetch_seq (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .lookup_pc   (lookup_pc),
        .hit         (hit),
        .hit_inst    (hit_inst),
        .fetch_valid (fetch_valid),
        .fetch_out   (fetch_out)
    );

    icache_store u_icache_store (
        .clk             (clk),
        .reset           (reset),
        .lookup_pc       (lookup_pc),
        .hit             (hit),
        .hit_inst        (hit_inst),
        .tag_wr          (tag_wr),
        .tag_wr_index    (tag_wr_index),
        .tag_wr_tag      (tag_wr_tag),
        .data_wr         (data_wr),
        .data_wr_index   (data_wr_index),
        .data_wr_offset  (data_wr_offset),
        .data_wr_word    (data_wr_word),
        .line_done       (line_done),
        .line_done_index (line_done_index)
    );

    icache_refill u_icache_refill (
        .clk             (clk),
        .reset           (reset),
        .lookup_pc       (lookup_pc),
        .hit             (hit),
        .tag_wr          (tag_wr),
        .tag_wr_index    (tag_wr_index),
        .tag_wr_tag      (tag_wr_tag),
        .data_wr         (data_wr),
        .data_wr_index   (data_wr_index),
        .data_wr_offset  (data_wr_offset),
        .data_wr_word    (data_wr_word),
        .line_done       (line_done),
        .line_done_index (line_done_index),
        .arid            (arid),
        .araddr          (araddr),
        .arlen           (arlen),
        .arsize          (arsize),
        .arburst         (arburst),
        .arlock          (arlock),
        .arcache         (arcache),
        .arprot          (arprot),
        .arvalid         (arvalid),
        .arready         (arready),
        .rid             (rid),
        .rdata           (rdata),
        .rresp           (rresp),
        .rlast           (rlast),
        .rvalid          (rvalid),
        .rready          (rready)
    );

endmodule

`default_nettype wire

/* src/fetch_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_seq (
    input  wire logic                 clk,
    input  wire logic                 reset,

    // redirect from outside, single-cycle pulse
    input  wire logic                 redirect,
    input  wire icache_pkg::addr_t    redirect_pc,

    // cache lookup
    output icache_pkg::addr_t         lookup_pc,
    input  wire logic                 hit,
    input  wire icache_pkg::inst_t    hit_inst,

    // delivered instructions
    output logic                      fetch_valid,
    output icache_pkg::fetch_out_t    fetch_out
);
    import icache_pkg::*;

    addr_t pc;
    logic  deliver;

    // a lookup in the redirect cycle belongs to the old stream
    assign deliver   = hit && !redirect;
    assign lookup_pc = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= deliver;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (hit) begin
                pc <= pc + addr_t'(inst_bytes);          // next sequential instruction
            end
        end
    end

    // payload follows the strobe
    always_ff @(posedge clk) begin
        if (deliver) begin
            fetch_out.pc   <= pc;
            fetch_out.inst <= hit_inst;
        end
    end

endmodule

`default_nettype wire

/* src/icache_refill.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_refill (
    input  wire logic                 clk,
    input  wire logic                 reset,

    // miss detection
    input  wire icache_pkg::addr_t    lookup_pc,
    input  wire logic                 hit,

    // writes into the store
    output logic                      tag_wr,
    output icache_pkg::index_t        tag_wr_index,
    output icache_pkg::tag_t          tag_wr_tag,
    output logic                      data_wr,
    output icache_pkg::index_t        data_wr_index,
    output icache_pkg::offset_t       data_wr_offset,
    output icache_pkg::word_t         data_wr_word,
    output logic                      line_done,
    output icache_pkg::index_t        line_done_index,

    // AXI read address channel
    output icache_pkg::axi_id_t       arid,
    output icache_pkg::addr_t         araddr,
    output logic [7:0]                arlen,
    output logic [2:0]                arsize,
    output logic [1:0]                arburst,
    output logic                      arlock,
    output logic [3:0]                arcache,
    output logic [2:0]                arprot,
    output logic                      arvalid,
    input  wire logic                 arready,

    // AXI read data channel
    input  wire icache_pkg::axi_id_t  rid,
    input  wire icache_pkg::word_t    rdata,
    input  wire logic [1:0]           rresp,
    input  wire logic                 rlast,
    input  wire logic                 rvalid,
    output logic                      rready
);
    import icache_pkg::*;

    refill_state_t state;
    addr_t         miss_pc;                              // word aligned
    offset_t       fill_offset;                          // wraps with the burst
    index_t        miss_index;
    offset_t       start_offset;
    logic          miss;

    assign miss         = (state == idle) && !hit;
    assign miss_index   = miss_pc[tag_lsb-1:index_lsb];
    assign start_offset = miss_pc[index_lsb-1:word_bytes_log];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: if (miss) state <= addr;
                addr: if (arready) state <= data;        // arvalid is high here
                data: if (rvalid && rlast) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            miss_pc     <= {lookup_pc[addr_width-1:word_bytes_log], {word_bytes_log{1'b0}}};
            fill_offset <= lookup_pc[index_lsb-1:word_bytes_log];
        end else if (data_wr) begin
            fill_offset <= fill_offset + offset_t'(1);
        end
    end

    // store side
    assign tag_wr          = (state == addr);            // tag plus invalidate
    assign tag_wr_index    = miss_index;
    assign tag_wr_tag      = miss_pc[addr_width-1:tag_lsb];
    assign data_wr         = (state == data) && rvalid;
    assign data_wr_index   = miss_index;
    assign data_wr_offset  = fill_offset;
    assign data_wr_word    = rdata;
    assign line_done       = data_wr && rlast;
    assign line_done_index = miss_index;

    // AXI side, fixed burst shape
    assign arid    = '0;
    assign araddr  = miss_pc;
    assign arlen   = burst_len;
    assign arsize  = burst_size;
    assign arburst = burst_wrap;
    assign arlock  = 1'b0;
    assign arcache = arcache_none;
    assign arprot  = arprot_inst;
    assign arvalid = (state == addr);
    assign rready  = (state == data);

    a_rid_zero: assert property (
        @(posedge clk) disable iff (reset)
        (rvalid && rready) |-> (rid == '0)
    );

    // instruction memory is not expected to answer with an error
    a_rresp_okay: assert property (
        @(posedge clk) disable iff (reset)
        (rvalid && rready) |-> (rresp == 2'b00)
    );

    // eighth beat is the one whose offset wraps back to the start
    a_rlast_eighth: assert property (
        @(posedge clk) disable iff (reset)
        (rvalid && rready) |-> (rlast == (offset_t'(fill_offset + offset_t'(1)) == start_offset))
    );

    a_arvalid_hold: assert property (
        @(posedge clk) disable iff (reset)
        (arvalid && !arready) |=> arvalid
    );

endmodule

`default_nettype wire

/* src/icache_store.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_store (
    input  wire logic                 clk,
    input  wire logic                 reset,

    // lookup from the fetch sequencer
    input  wire icache_pkg::addr_t    lookup_pc,
    output logic                      hit,
    output icache_pkg::inst_t         hit_inst,

    // tag write, also invalidates the line
    input  wire logic                 tag_wr,
    input  wire icache_pkg::index_t   tag_wr_index,
    input  wire icache_pkg::tag_t     tag_wr_tag,

    // one word of a refill
    input  wire logic                 data_wr,
    input  wire icache_pkg::index_t   data_wr_index,
    input  wire icache_pkg::offset_t  data_wr_offset,
    input  wire icache_pkg::word_t    data_wr_word,

    // last beat written, line becomes valid
    input  wire logic                 line_done,
    input  wire icache_pkg::index_t   line_done_index
);
    import icache_pkg::*;

    word_t      data_mem [sets*line_words];               // indexed by {index, offset}
    tag_t       tag_mem  [sets];
    logic [sets-1:0] line_valid;

    index_t     lk_index;
    offset_t    lk_offset;
    tag_t       lk_tag;
    word_t      lk_word;

    // split the lookup address
    assign lk_index  = lookup_pc[tag_lsb-1:index_lsb];
    assign lk_offset = lookup_pc[index_lsb-1:word_bytes_log];
    assign lk_tag    = lookup_pc[addr_width-1:tag_lsb];

    assign lk_word = data_mem[{lk_index, lk_offset}];

    assign hit = line_valid[lk_index] && (tag_mem[lk_index] == lk_tag);

    // bit 2 picks the upper instruction of the 64-bit word
    assign hit_inst = lookup_pc[word_bytes_log-1] ? lk_word[data_width-1:inst_width]
                                                  : lk_word[inst_width-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
        end else begin
            if (tag_wr) begin
                line_valid[tag_wr_index] <= 1'b0;        // line being replaced
            end
            if (line_done) begin
                line_valid[line_done_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tag_mem[tag_wr_index] <= tag_wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            data_mem[{data_wr_index, data_wr_offset}] <= data_wr_word;
        end
    end

    // the refill never sets and clears the same line in one cycle
    a_no_done_on_tag_wr: assert property (
        @(posedge clk) disable iff (reset)
        (line_done && tag_wr) |-> (line_done_index != tag_wr_index)
    );

    // beats only land in a line that was invalidated first
    a_fill_invalid_line: assert property (
        @(posedge clk) disable iff (reset)
        data_wr |-> !line_valid[data_wr_index]
    );

endmodule

`default_nettype wire

/* src/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int addr_width     = 64;
    localparam int data_width     = 64;                  // one AXI beat
    localparam int inst_width     = 32;
    localparam int word_bytes_log = 3;                   // 8 bytes per word
    localparam int line_words_log = 3;                   // 8 words per line
    localparam int sets_log       = 8;                   // 256 sets
    localparam int id_width       = 13;

    localparam int line_words = 1 << line_words_log;
    localparam int sets       = 1 << sets_log;
    localparam int index_lsb  = word_bytes_log + line_words_log;   // bit 6
    localparam int tag_lsb    = index_lsb + sets_log;              // bit 14
    localparam int tag_width  = addr_width - tag_lsb;              // 50 bits
    localparam int inst_bytes = inst_width / 8;                    // pc step

    // address fields and data words
    typedef logic [addr_width-1:0]     addr_t;
    typedef logic [data_width-1:0]     word_t;
    typedef logic [inst_width-1:0]     inst_t;
    typedef logic [sets_log-1:0]       index_t;
    typedef logic [line_words_log-1:0] offset_t;
    typedef logic [tag_width-1:0]      tag_t;
    typedef logic [id_width-1:0]       axi_id_t;

    // fixed AR fields of a line refill
    localparam logic [7:0] burst_len    = 8'd7;          // 8 beats
    localparam logic [2:0] burst_size   = 3'd3;          // 8 bytes per beat
    localparam logic [1:0] burst_wrap   = 2'd2;          // critical word first
    localparam logic [2:0] arprot_inst  = 3'd6;          // instruction, non-secure
    localparam logic [3:0] arcache_none = 4'd0;

    typedef enum logic [1:0] {
        idle,
        addr,                                            // AR handshake pending
        data                                             // beats streaming in
    } refill_state_t;

    // one delivered instruction
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_out_t;

endpackage

`default_nettype wire
